// ==== dv/clk_rst_gen.sv ====
////////////////////////////////////////////////////////////
// Free-running clock, reset released on a rising edge
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module clk_rst_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule

// ==== dv/tb_exec_mem_core.sv ====
////////////////////////////////////////////////////////////
// Small memory depth so random addresses wrap and collide
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_exec_mem_core;

    import exec_pkg::*;

    localparam int DMEM_WORDS = 64;
    localparam int N_ALU      = 200;
    localparam int N_MEM      = 60;
    localparam int N_BR       = 120;
    localparam int N_MIX      = 300;
    localparam int TOTAL_OPS  = DMEM_WORDS + N_ALU + 3 * N_MEM + N_BR + N_MIX + 1;
    localparam longint WATCHDOG_NS = longint'(TOTAL_OPS * 40 + 100) * 20;

    typedef struct packed {
        logic      rw;
        reg_addr_t rd;
        word_t     data;
        logic      redir;
        word_t     tgt;
    } result_t;

    logic      clk_i;
    logic      arst_n_i;
    logic      op_valid_i;
    logic      op_ready_o;
    alu_op_e   op_alu_i;
    branch_e   op_branch_i;
    wb_sel_e   op_wb_sel_i;
    logic      op_reg_write_i;
    logic      op_mem_read_i;
    logic      op_mem_write_i;
    reg_addr_t op_rd_i;
    word_t     op_a_i;
    word_t     op_b_i;
    word_t     op_store_data_i;
    word_t     op_pc_i;
    word_t     op_imm_i;
    logic      wb_valid_o;
    logic      wb_ready_i;
    logic      wb_reg_write_o;
    reg_addr_t wb_rd_o;
    word_t     wb_data_o;
    logic      wb_redirect_o;
    word_t     wb_redirect_pc_o;

    word_t     model_mem [DMEM_WORDS];
    result_t   exp_q [$];
    bit        stall_mode;

    clk_rst_gen #(.PERIOD_NS(20), .RESET_CYCLES(8)) u_clk_rst_gen (
        .clk_o    (clk_i),
        .arst_n_o (arst_n_i)
    );

    exec_mem_core #(.DMEM_WORDS(DMEM_WORDS)) u_exec_mem_core (.*);

    task automatic fail_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input word_t want, input word_t got);
        assert (got === want) else begin
            $display("[FAIL] %s expected %h got %h", name, want, got);
            fail_run();
        end
    endtask

    // Expected writeback for the operation now on the input port
    function automatic result_t predict_result();
        result_t r;
        word_t   alu;
        int      idx;
        case (op_alu_i)
            ALU_ADD:  alu = op_a_i + op_b_i;
            ALU_SUB:  alu = op_a_i - op_b_i;
            ALU_AND:  alu = op_a_i & op_b_i;
            ALU_OR:   alu = op_a_i | op_b_i;
            ALU_XOR:  alu = op_a_i ^ op_b_i;
            ALU_SLL:  alu = op_a_i << op_b_i[4:0];
            ALU_SRL:  alu = op_a_i >> op_b_i[4:0];
            ALU_SRA:  alu = $signed(op_a_i) >>> op_b_i[4:0];
            ALU_SLT:  alu = ($signed(op_a_i) < $signed(op_b_i)) ? 32'd1 : 32'd0;
            default:  alu = (op_a_i < op_b_i) ? 32'd1 : 32'd0;
        endcase
        idx = int'(alu[31:2] % DMEM_WORDS);
        r.rw  = op_reg_write_i;
        r.rd  = op_rd_i;
        r.tgt = op_pc_i + op_imm_i;
        case (op_branch_i)
            BR_JUMP: r.redir = 1'b1;
            BR_EQ:   r.redir = (op_a_i == op_b_i);
            BR_NE:   r.redir = (op_a_i != op_b_i);
            BR_LT:   r.redir = ($signed(op_a_i) < $signed(op_b_i));
            default: r.redir = 1'b0;
        endcase
        case (op_wb_sel_i)
            WB_MEM:  r.data = op_mem_read_i ? model_mem[idx] : 32'd0;
            WB_LINK: r.data = op_pc_i + 32'd4;
            default: r.data = alu;
        endcase
        if (op_mem_write_i) begin
            model_mem[idx] = op_store_data_i;
        end
        return r;
    endfunction

    always @(posedge clk_i) begin
        if (arst_n_i && op_valid_i && op_ready_o) begin
            exp_q.push_back(predict_result());
        end
    end

    always @(posedge clk_i) begin
        result_t want;
        if (arst_n_i && wb_valid_o && wb_ready_i) begin
            assert (exp_q.size() > 0) else begin
                $display("Result delivered with no operation outstanding");
                fail_run();
            end
            want = exp_q.pop_front();
            check_value("wb_reg_write_o", want.rw, wb_reg_write_o);
            check_value("wb_rd_o", want.rd, wb_rd_o);
            check_value("wb_data_o", want.data, wb_data_o);
            check_value("wb_redirect_o", want.redir, wb_redirect_o);
            check_value("wb_redirect_pc_o", want.tgt, wb_redirect_pc_o);
        end
    end

    always @(posedge clk_i) begin
        wb_ready_i <= stall_mode ? 1'($urandom_range(1)) : 1'b1;  // Back-pressure
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all results arrived");
        fail_run();
    end

    task automatic send_op(input alu_op_e alu, input branch_e br, input wb_sel_e wbs,
                           input logic rw, input logic mr, input logic mw,
                           input word_t a, input word_t b, input word_t sd);
        if (stall_mode && $urandom_range(2) == 0) begin
            op_valid_i <= 1'b0;  // Idle gap
            @(posedge clk_i);
        end
        op_valid_i      <= 1'b1;
        op_alu_i        <= alu;
        op_branch_i     <= br;
        op_wb_sel_i     <= wbs;
        op_reg_write_i  <= rw;
        op_mem_read_i   <= mr;
        op_mem_write_i  <= mw;
        op_rd_i         <= reg_addr_t'($urandom);
        op_a_i          <= a;
        op_b_i          <= b;
        op_store_data_i <= sd;
        op_pc_i         <= $urandom & ~32'h3;
        op_imm_i        <= $urandom;
        do @(posedge clk_i); while (!op_ready_o);
        op_valid_i <= 1'b0;
    endtask

    task automatic send_store(input word_t a, input word_t b, input word_t data);
        send_op(ALU_ADD, BR_NONE, WB_ALU, 1'b0, 1'b0, 1'b1, a, b, data);
    endtask

    task automatic send_load(input word_t a, input word_t b);
        send_op(ALU_ADD, BR_NONE, WB_MEM, 1'b1, 1'b1, 1'b0, a, b, $urandom);
    endtask

    task automatic send_alu_rand();
        send_op(alu_op_e'($urandom_range(9)), BR_NONE, WB_ALU, 1'b1, 1'b0, 1'b0,
                $urandom, $urandom, $urandom);
    endtask

    task automatic send_branch_rand();
        branch_e br;
        word_t   a;
        br = branch_e'($urandom_range(4));
        a  = $urandom;
        send_op(ALU_SUB, br, (br == BR_JUMP) ? WB_LINK : WB_ALU, br == BR_JUMP,
                1'b0, 1'b0, a, $urandom_range(1) ? a : word_t'($urandom), $urandom);
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) @(posedge clk_i);
    endtask

    initial begin
        word_t a;
        void'($urandom(32'h09846f3c));
        stall_mode      = 1'b0;
        op_valid_i      <= 1'b0;
        op_alu_i        <= ALU_ADD;
        op_branch_i     <= BR_NONE;
        op_wb_sel_i     <= WB_ALU;
        op_reg_write_i  <= 1'b0;
        op_mem_read_i   <= 1'b0;
        op_mem_write_i  <= 1'b0;
        op_rd_i         <= '0;
        op_a_i          <= '0;
        op_b_i          <= '0;
        op_store_data_i <= '0;
        op_pc_i         <= '0;
        op_imm_i        <= '0;
        wb_ready_i      <= 1'b1;
        repeat (3) @(posedge clk_i);
        check_value("wb_valid_o", 1'b0, wb_valid_o);
        check_value("op_ready_o", 1'b1, op_ready_o);
        @(posedge arst_n_i);
        @(posedge clk_i);
        check_value("wb_valid_o", 1'b0, wb_valid_o);
        check_value("op_ready_o", 1'b1, op_ready_o);
        for (int i = 0; i < DMEM_WORDS; i++) begin
            send_store(word_t'(i) << 2, 32'd0, (i * 32'h0101_0101) ^ 32'h5ac3_96e1);
        end
        repeat (N_ALU) send_alu_rand();
        for (int i = 0; i < N_MEM; i++) begin
            a = $urandom;
            send_store(a, 32'd0, $urandom);
            send_load(a + word_t'($urandom_range(1, 7) * DMEM_WORDS * 4), 32'd0);  // Aliased
            send_load($urandom, $urandom_range(255));
        end
        repeat (N_BR) send_branch_rand();
        stall_mode = 1'b1;
        for (int i = 0; i < N_MIX; i++) begin
            case ($urandom_range(3))
                0:       send_alu_rand();
                1:       send_store($urandom, $urandom_range(255), $urandom);
                2:       send_load($urandom, $urandom_range(255));
                default: send_branch_rand();
            endcase
        end
        stall_mode = 1'b0;
        wait_drain();
        @(posedge clk_i);
        send_alu_rand();
        @(posedge clk_i);
        check_value("wb_valid_o", 1'b0, wb_valid_o);
        @(posedge clk_i);
        check_value("wb_valid_o", 1'b1, wb_valid_o);  // Second edge after acceptance
        wait_drain();
        @(posedge clk_i);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== exec_mem_core.f ====
logic/exec_pkg.sv
logic/pipe_ctrl.sv
logic/execute_unit.sv
logic/execute_memory_register.sv
logic/data_mem_stage.sv
logic/exec_mem_core.sv
dv/clk_rst_gen.sv
dv/tb_exec_mem_core.sv

// ==== logic/data_mem_stage.sv ====
////////////////////////////////////////////////////////////
// Word accesses only, address bits [1:0] are ignored
// DMEM_WORDS must be a power of two, at least 2
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module data_mem_stage #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                en_i,

    input  exec_pkg::word_t     em_pcsrc_i,
    input  exec_pkg::word_t     em_pc_new_i,
    input  exec_pkg::word_t     em_alu_result_i,
    input  exec_pkg::word_t     em_read_data2_i,
    input  logic                em_pc_select_i,
    input  logic                em_reg_write_i,
    input  logic                em_mem_read_i,
    input  logic                em_mem_write_i,
    input  exec_pkg::wb_sel_e   em_dmem_to_reg_i,
    input  exec_pkg::reg_addr_t em_write_addr_reg_i,

    output logic                wb_reg_write_o,
    output exec_pkg::reg_addr_t wb_rd_o,
    output exec_pkg::word_t     wb_data_o,
    output logic                wb_redirect_o,
    output exec_pkg::word_t     wb_redirect_pc_o
);

    import exec_pkg::*;

    localparam int IDX_W = $clog2(DMEM_WORDS);

    word_t            mem_q [DMEM_WORDS];
    logic [IDX_W-1:0] mem_idx;
    word_t            load_word;
    word_t            wb_value;

    assign mem_idx   = em_alu_result_i[IDX_W+1:2];  // Wraps modulo depth
    assign load_word = em_mem_read_i ? mem_q[mem_idx] : '0;

    always_ff @(posedge clk_i) begin
        if (en_i && em_mem_write_i) begin
            mem_q[mem_idx] <= em_read_data2_i;
        end
    end

    always_comb begin
        case (em_dmem_to_reg_i)
            WB_MEM:  wb_value = load_word;
            WB_LINK: wb_value = em_pcsrc_i;
            default: wb_value = em_alu_result_i;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            wb_reg_write_o   <= em_reg_write_i;
            wb_rd_o          <= em_write_addr_reg_i;
            wb_data_o        <= wb_value;
            wb_redirect_pc_o <= em_pc_new_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_redirect_o <= 1'b0;
        end else if (en_i) begin
            wb_redirect_o <= em_pc_select_i;
        end
    end

endmodule

// ==== logic/exec_mem_core.sv ====
////////////////////////////////////////////////////////////
// Payload must stay stable while op_valid_i waits for ready
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module exec_mem_core #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                clk_i,
    input  logic                arst_n_i,

    input  logic                op_valid_i,
    output logic                op_ready_o,
    input  exec_pkg::alu_op_e   op_alu_i,
    input  exec_pkg::branch_e   op_branch_i,
    input  exec_pkg::wb_sel_e   op_wb_sel_i,
    input  logic                op_reg_write_i,
    input  logic                op_mem_read_i,
    input  logic                op_mem_write_i,
    input  exec_pkg::reg_addr_t op_rd_i,
    input  exec_pkg::word_t     op_a_i,
    input  exec_pkg::word_t     op_b_i,
    input  exec_pkg::word_t     op_store_data_i,
    input  exec_pkg::word_t     op_pc_i,
    input  exec_pkg::word_t     op_imm_i,

    output logic                wb_valid_o,
    input  logic                wb_ready_i,
    output logic                wb_reg_write_o,
    output exec_pkg::reg_addr_t wb_rd_o,
    output exec_pkg::word_t     wb_data_o,
    output logic                wb_redirect_o,
    output exec_pkg::word_t     wb_redirect_pc_o
);

    import exec_pkg::*;

    logic      ex_mem_en;
    logic      mem_en;

    word_t     alu_result;
    word_t     link;
    word_t     target;
    logic      taken;

    word_t     em_pcsrc;
    word_t     em_pc_new;
    word_t     em_alu_result;
    word_t     em_read_data2;
    logic      em_pc_select;
    logic      em_reg_write;
    logic      em_mem_read;
    logic      em_mem_write;
    wb_sel_e   em_dmem_to_reg;
    reg_addr_t em_write_addr_reg;

    pipe_ctrl u_pipe_ctrl (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .op_valid_i  (op_valid_i),
        .wb_ready_i  (wb_ready_i),
        .op_ready_o  (op_ready_o),
        .ex_mem_en_o (ex_mem_en),
        .mem_en_o    (mem_en),
        .wb_valid_o  (wb_valid_o)
    );

    execute_unit u_execute_unit (
        .alu_op_i     (op_alu_i),
        .branch_i     (op_branch_i),
        .a_i          (op_a_i),
        .b_i          (op_b_i),
        .pc_i         (op_pc_i),
        .imm_i        (op_imm_i),
        .alu_result_o (alu_result),
        .link_o       (link),
        .target_o     (target),
        .taken_o      (taken)
    );

    execute_memory_register u_execute_memory_register (
        .clk_i               (clk_i),
        .en_i                (ex_mem_en),
        .pcsrc_i             (link),
        .pc_new_i            (target),
        .alu_result_i        (alu_result),
        .read_data2_i        (op_store_data_i),
        .pc_select_i         (taken),
        .reg_write_i         (op_reg_write_i),
        .mem_read_i          (op_mem_read_i),
        .mem_write_i         (op_mem_write_i),
        .dmem_to_reg_i       (op_wb_sel_i),
        .write_addr_reg_i    (op_rd_i),
        .em_pcsrc_o          (em_pcsrc),
        .em_pc_new_o         (em_pc_new),
        .em_alu_result_o     (em_alu_result),
        .em_read_data2_o     (em_read_data2),
        .em_pc_select_o      (em_pc_select),
        .em_reg_write_o      (em_reg_write),
        .em_mem_read_o       (em_mem_read),
        .em_mem_write_o      (em_mem_write),
        .em_dmem_to_reg_o    (em_dmem_to_reg),
        .em_write_addr_reg_o (em_write_addr_reg)
    );

    data_mem_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_data_mem_stage (
        .clk_i               (clk_i),
        .arst_n_i            (arst_n_i),
        .en_i                (mem_en),
        .em_pcsrc_i          (em_pcsrc),
        .em_pc_new_i         (em_pc_new),
        .em_alu_result_i     (em_alu_result),
        .em_read_data2_i     (em_read_data2),
        .em_pc_select_i      (em_pc_select),
        .em_reg_write_i      (em_reg_write),
        .em_mem_read_i       (em_mem_read),
        .em_mem_write_i      (em_mem_write),
        .em_dmem_to_reg_i    (em_dmem_to_reg),
        .em_write_addr_reg_i (em_write_addr_reg),
        .wb_reg_write_o      (wb_reg_write_o),
        .wb_rd_o             (wb_rd_o),
        .wb_data_o           (wb_data_o),
        .wb_redirect_o       (wb_redirect_o),
        .wb_redirect_pc_o    (wb_redirect_pc_o)
    );

endmodule

// ==== logic/exec_pkg.sv ====
////////////////////////////////////////////////////////////
// Widths and fixed encodings for the execute/memory back end
// The front end must drive the enum fields with these codes
////////////////////////////////////////////////////////////
package exec_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;     // Operands, results, pc, immediate
    typedef logic [4:0]      reg_addr_t; // Destination register index

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0, // Never taken
        BR_JUMP = 3'd1, // Always taken
        BR_EQ   = 3'd2,
        BR_NE   = 3'd3,
        BR_LT   = 3'd4  // Signed compare
    } branch_e;

    // Writeback source
    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_MEM  = 2'd1,
        WB_LINK = 2'd2  // pc + 4
    } wb_sel_e;

endpackage

// ==== logic/execute_memory_register.sv ====
////////////////////////////////////////////////////////////
// Payload only, validity is held in pipe_ctrl
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module execute_memory_register (
    input  logic                clk_i,
    input  logic                en_i,

    input  exec_pkg::word_t     pcsrc_i,
    input  exec_pkg::word_t     pc_new_i,
    input  exec_pkg::word_t     alu_result_i,
    input  exec_pkg::word_t     read_data2_i,
    input  logic                pc_select_i,
    input  logic                reg_write_i,
    input  logic                mem_read_i,
    input  logic                mem_write_i,
    input  exec_pkg::wb_sel_e   dmem_to_reg_i,
    input  exec_pkg::reg_addr_t write_addr_reg_i,

    output exec_pkg::word_t     em_pcsrc_o,
    output exec_pkg::word_t     em_pc_new_o,
    output exec_pkg::word_t     em_alu_result_o,
    output exec_pkg::word_t     em_read_data2_o,
    output logic                em_pc_select_o,
    output logic                em_reg_write_o,
    output logic                em_mem_read_o,
    output logic                em_mem_write_o,
    output exec_pkg::wb_sel_e   em_dmem_to_reg_o,
    output exec_pkg::reg_addr_t em_write_addr_reg_o
);

    // Holds during stalls
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            em_pcsrc_o          <= pcsrc_i;
            em_pc_new_o         <= pc_new_i;
            em_pc_select_o      <= pc_select_i;

            em_reg_write_o      <= reg_write_i;
            em_mem_read_o       <= mem_read_i;
            em_mem_write_o      <= mem_write_i;
            em_dmem_to_reg_o    <= dmem_to_reg_i;

            em_write_addr_reg_o <= write_addr_reg_i;
            em_alu_result_o     <= alu_result_i;
            em_read_data2_o     <= read_data2_i;  // Store data
        end
    end

endmodule

// ==== logic/execute_unit.sv ====
////////////////////////////////////////////////////////////
// Purely combinational, shifts use b[4:0]
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module execute_unit (
    input  exec_pkg::alu_op_e alu_op_i,
    input  exec_pkg::branch_e branch_i,
    input  exec_pkg::word_t   a_i,
    input  exec_pkg::word_t   b_i,
    input  exec_pkg::word_t   pc_i,
    input  exec_pkg::word_t   imm_i,
    output exec_pkg::word_t   alu_result_o,
    output exec_pkg::word_t   link_o,
    output exec_pkg::word_t   target_o,
    output logic              taken_o
);

    import exec_pkg::*;

    logic [4:0] shamt;
    logic       a_eq_b;
    logic       a_lt_b;

    assign shamt  = b_i[4:0];
    assign a_eq_b = (a_i == b_i);
    assign a_lt_b = ($signed(a_i) < $signed(b_i));

    always_comb begin
        case (alu_op_i)
            ALU_ADD:  alu_result_o = a_i + b_i;
            ALU_SUB:  alu_result_o = a_i - b_i;
            ALU_AND:  alu_result_o = a_i & b_i;
            ALU_OR:   alu_result_o = a_i | b_i;
            ALU_XOR:  alu_result_o = a_i ^ b_i;
            ALU_SLL:  alu_result_o = a_i << shamt;
            ALU_SRL:  alu_result_o = a_i >> shamt;
            ALU_SRA:  alu_result_o = word_t'($signed(a_i) >>> shamt);
            ALU_SLT:  alu_result_o = {{(XLEN-1){1'b0}}, a_lt_b};
            ALU_SLTU: alu_result_o = {{(XLEN-1){1'b0}}, (a_i < b_i)};
            default:  alu_result_o = '0;  // Unused codes
        endcase
    end

    always_comb begin
        case (branch_i)
            BR_JUMP: taken_o = 1'b1;
            BR_EQ:   taken_o = a_eq_b;
            BR_NE:   taken_o = !a_eq_b;
            BR_LT:   taken_o = a_lt_b;
            default: taken_o = 1'b0;
        endcase
    end

    assign link_o   = pc_i + word_t'(4);
    assign target_o = pc_i + imm_i;     // Branch and jump target

endmodule

// ==== logic/pipe_ctrl.sv ====
////////////////////////////////////////////////////////////
// Occupancy of EX/MEM and the output slot, one entry each
// Register enables fire only for valid entries
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module pipe_ctrl (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic op_valid_i,
    input  logic wb_ready_i,
    output logic op_ready_o,
    output logic ex_mem_en_o,
    output logic mem_en_o,
    output logic wb_valid_o
);

    logic ex_mem_valid;
    logic mem_valid;
    logic mem_adv;
    logic ex_mem_adv;

    assign mem_adv    = !mem_valid || wb_ready_i;   // Output slot empty or draining
    assign ex_mem_adv = !ex_mem_valid || mem_adv;   // EX/MEM empty or moving on

    // An empty slot never reloads stale payload, so a store is not replayed
    assign ex_mem_en_o = ex_mem_adv && op_valid_i;
    assign mem_en_o    = mem_adv && ex_mem_valid;

    assign op_ready_o = ex_mem_adv;
    assign wb_valid_o = mem_valid;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_mem_valid <= 1'b0;
            mem_valid    <= 1'b0;
        end else begin
            if (ex_mem_adv) begin
                ex_mem_valid <= op_valid_i;
            end
            if (mem_adv) begin
                mem_valid <= ex_mem_valid;
            end
        end
    end

endmodule
